//--- cmd_dispatch.sv
`default_nettype none

module cmd_dispatch #(
   parameter int NUM_CHAN = 4
) (
   input  logic                       clk,
   input  logic                       rst_n,
   input  uart_link_pkg::cmd_t        cmd,
   input  logic                       cmd_vld,
   output logic                       cmd_rdy,
   input  logic [NUM_CHAN-1:0]        busy,
   output logic [NUM_CHAN-1:0]        load,
   output logic [NUM_CHAN-1:0][15:0]  word
);

   logic [NUM_CHAN-1:0]       slot_vld;
   logic [NUM_CHAN-1:0][15:0] slot_word;
   logic [NUM_CHAN-1:0]       tx_free;  // no frame on the line and no load in flight
   logic [NUM_CHAN-1:0]       fwd;      // held command leaves for its transmitter
   logic [NUM_CHAN-1:0]       take;     // accepted command addressed to this channel
   logic [NUM_CHAN-1:0]       direct;   // accepted command bypasses the slot
   logic                      accept;

   assign tx_free = ~busy & ~load;
   assign fwd     = slot_vld & tx_free;

   // refuse only when the slot is full and its transmitter cannot take it
   assign cmd_rdy = (int'(cmd.chan) < NUM_CHAN) &&
                    !(slot_vld[cmd.chan] && !tx_free[cmd.chan]);
   assign accept  = cmd_vld && cmd_rdy;

   always_comb begin
      for (int i = 0; i < NUM_CHAN; i++) begin
         take[i]   = accept && (int'(cmd.chan) == i);
         direct[i] = take[i] && tx_free[i] && !slot_vld[i];
      end
   end

   always_ff @(posedge clk) begin
      for (int i = 0; i < NUM_CHAN; i++) begin
         if (take[i] && !direct[i])
            slot_word[i] <= cmd.word;
         if (fwd[i])
            word[i] <= slot_word[i];
         else if (direct[i])
            word[i] <= cmd.word;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         slot_vld <= '0;
         load     <= '0;
      end else begin
         load <= fwd | direct;
         for (int i = 0; i < NUM_CHAN; i++) begin
            if (take[i] && !direct[i])
               slot_vld[i] <= 1'b1;  // may refill in the same cycle it forwards
            else if (fwd[i])
               slot_vld[i] <= 1'b0;
         end
      end
   end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build and run the uart_link testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module uart_link_tb -f uart_link.f -o uart_link_sim
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit 1
fi

output=$(./obj_dir/uart_link_sim 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -qx "Test passed"; then
   exit 0
fi
exit 1

//--- rx_collector.sv
`default_nettype none

module rx_collector #(
   parameter int NUM_CHAN = 4
) (
   input  logic                                     clk,
   input  logic                                     rst_n,
   input  logic [NUM_CHAN-1:0]                      byte_vld,
   input  uart_frame_pkg::rx_byte_t [NUM_CHAN-1:0]  rx_byte,
   output logic                                     read_vld,
   output uart_link_pkg::read_rec_t                 read_rec
);

   logic [NUM_CHAN-1:0]                     slot_full;
   logic [NUM_CHAN-1:0]                     slot_ovr;
   uart_frame_pkg::rx_byte_t [NUM_CHAN-1:0] slot_byte;
   logic [uart_link_pkg::CHAN_W-1:0]        last;  // channel served most recently
   logic [uart_link_pkg::CHAN_W-1:0]        pick;
   logic                                    pick_vld;

   // search starts one past the last served channel and wraps
   always_comb begin
      pick_vld = 1'b0;
      pick     = last;
      for (int k = 1; k <= NUM_CHAN; k++) begin
         logic [uart_link_pkg::CHAN_W-1:0] idx;
         idx = uart_link_pkg::CHAN_W'((int'(last) + k) % NUM_CHAN);
         if (!pick_vld && slot_full[idx]) begin
            pick_vld = 1'b1;
            pick     = idx;
         end
      end
   end

   always_ff @(posedge clk) begin
      for (int i = 0; i < NUM_CHAN; i++) begin
         if (byte_vld[i])
            slot_byte[i] <= rx_byte[i];
      end
      if (pick_vld) begin
         read_rec.chan    <= pick;
         read_rec.rx_byte <= slot_byte[pick];
         read_rec.overrun <= slot_ovr[pick];
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         slot_full <= '0;
         slot_ovr  <= '0;
         last      <= '0;
         read_vld  <= 1'b0;
      end else begin
         read_vld <= pick_vld;
         if (pick_vld) begin
            last            <= pick;
            slot_full[pick] <= 1'b0;
         end
         // a new byte wins over the drain in the same cycle
         for (int i = 0; i < NUM_CHAN; i++) begin
            if (byte_vld[i]) begin
               slot_full[i] <= 1'b1;
               slot_ovr[i]  <= slot_full[i] && !(pick_vld && int'(pick) == i);
            end
         end
      end
   end

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
`default_nettype none

module tb_clock_gen #(
   parameter int HALF_PERIOD  = 2,
   parameter int RESET_CYCLES = 16
) (
   output logic clk,
   output logic rst_n
);

   initial begin
      clk = 1'b0;
      forever #HALF_PERIOD clk = ~clk;
   end

   // release lands just after a rising edge, away from the flops
   initial begin
      rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      rst_n = 1'b1;
   end

endmodule

`default_nettype wire

//--- uart_frame_pkg.sv
`default_nettype none

package uart_frame_pkg;

   // start, eight data bits lsb first, odd parity, stop
   localparam int FRAME_BITS = 11;
   localparam int DATA_BITS  = 8;

   typedef enum logic [2:0] {
      TX_IDLE,
      TX_START,
      TX_DATA,
      TX_PARITY,
      TX_STOP
   } tx_state_e;

   typedef enum logic [2:0] {
      RX_IDLE,
      RX_START,   // waiting for the middle of the start bit
      RX_DATA,
      RX_PARITY,
      RX_STOP
   } rx_state_e;

   typedef struct packed {
      logic [DATA_BITS-1:0] data;
      logic                 parity_err;  // ones in data plus parity came out even
      logic                 frame_err;   // stop bit sampled low
   } rx_byte_t;

endpackage

`default_nettype wire

//--- uart_link.f
uart_frame_pkg.sv
uart_link_pkg.sv
uart_tx.sv
uart_rx.sv
cmd_dispatch.sv
rx_collector.sv
uart_link.sv
tb_clock_gen.sv
uart_link_tb.sv

//--- uart_link.sv
`default_nettype none

module uart_link #(
   parameter int NUM_CHAN     = 4,
   parameter int CLKS_PER_BIT = 8
) (
   input  logic                     clk,
   input  logic                     rst_n,
   input  uart_link_pkg::cmd_t      cmd,
   input  logic                     cmd_vld,
   output logic                     cmd_rdy,
   output logic [NUM_CHAN-1:0]      tx,
   input  logic [NUM_CHAN-1:0]      rx,
   output logic                     read_vld,
   output uart_link_pkg::read_rec_t read_rec
);

   logic [NUM_CHAN-1:0]                     busy;
   logic [NUM_CHAN-1:0]                     load;
   logic [NUM_CHAN-1:0][15:0]               word;
   logic [NUM_CHAN-1:0]                     byte_vld;
   uart_frame_pkg::rx_byte_t [NUM_CHAN-1:0] rx_byte;

   cmd_dispatch #(
      .NUM_CHAN(NUM_CHAN)
   ) u_dispatch (
      .clk     (clk),
      .rst_n   (rst_n),
      .cmd     (cmd),
      .cmd_vld (cmd_vld),
      .cmd_rdy (cmd_rdy),
      .busy    (busy),
      .load    (load),
      .word    (word)
   );

   for (genvar i = 0; i < NUM_CHAN; i++) begin : g_chan
      uart_tx #(
         .CLKS_PER_BIT(CLKS_PER_BIT)
      ) u_tx (
         .clk   (clk),
         .rst_n (rst_n),
         .load  (load[i]),
         .word  (word[i]),
         .tx    (tx[i]),
         .busy  (busy[i])
      );

      uart_rx #(
         .CLKS_PER_BIT(CLKS_PER_BIT)
      ) u_rx (
         .clk      (clk),
         .rst_n    (rst_n),
         .rx       (rx[i]),
         .byte_vld (byte_vld[i]),
         .rx_byte  (rx_byte[i])
      );
   end

   rx_collector #(
      .NUM_CHAN(NUM_CHAN)
   ) u_collector (
      .clk      (clk),
      .rst_n    (rst_n),
      .byte_vld (byte_vld),
      .rx_byte  (rx_byte),
      .read_vld (read_vld),
      .read_rec (read_rec)
   );

endmodule

`default_nettype wire

//--- uart_link_pkg.sv
`default_nettype none

package uart_link_pkg;

   localparam int CHAN_W = 2;  // up to four channels

   // host command, the word goes out high byte first
   typedef struct packed {
      logic [CHAN_W-1:0] chan;
      logic [15:0]       word;
   } cmd_t;

   typedef struct packed {
      logic [CHAN_W-1:0]        chan;
      uart_frame_pkg::rx_byte_t rx_byte;
      logic                     overrun;  // an older byte of this channel was dropped
   } read_rec_t;

endpackage

`default_nettype wire

//--- uart_link_tb.sv
`default_nettype none

module uart_link_tb;

   localparam int NUM_CHAN      = 4;
   localparam int CLKS_PER_BIT  = 8;
   localparam int NUM_ROWS      = 22;
   localparam int SEND_TIMEOUT  = 1000;
   localparam int DRAIN_TIMEOUT = 2000;

   localparam logic [1:0] ACT_SEND   = 2'd0;
   localparam logic [1:0] ACT_REFUSE = 2'd1;  // strobe that must meet cmd_rdy low
   localparam logic [1:0] ACT_INJECT = 2'd2;
   localparam logic [1:0] ACT_DRAIN  = 2'd3;

   typedef struct packed {
      logic [1:0]  act;
      logic [1:0]  chan;
      logic        rnd;      // word is taken from the random stream
      logic [15:0] data;
      logic        bad_par;  // injected frame carries even parity
      logic        stop;
      logic        exp_pe;
      logic        exp_fe;
   } row_t;

   logic                     clk;
   logic                     rst_n;
   uart_link_pkg::cmd_t      cmd;
   logic                     cmd_vld;
   logic                     cmd_rdy;
   logic [NUM_CHAN-1:0]      tx;
   logic [NUM_CHAN-1:0]      rx;
   logic                     read_vld;
   uart_link_pkg::read_rec_t read_rec;
   logic [NUM_CHAN-1:0]      sel;       // 1 hands rx over to the frame generator
   logic [NUM_CHAN-1:0]      gen_line;
   integer                   seed;

   row_t                     stim_rows [NUM_ROWS];
   uart_link_pkg::read_rec_t exp_mem [NUM_CHAN][16];
   logic [3:0]               wr_ptr [NUM_CHAN];
   logic [3:0]               rd_ptr [NUM_CHAN];

   assign rx = (sel & gen_line) | (~sel & tx);

   tb_clock_gen u_clock (
      .clk   (clk),
      .rst_n (rst_n)
   );

   uart_link #(
      .NUM_CHAN     (NUM_CHAN),
      .CLKS_PER_BIT (CLKS_PER_BIT)
   ) DUT (
      .clk      (clk),
      .rst_n    (rst_n),
      .cmd      (cmd),
      .cmd_vld  (cmd_vld),
      .cmd_rdy  (cmd_rdy),
      .tx       (tx),
      .rx       (rx),
      .read_vld (read_vld),
      .read_rec (read_rec)
   );

   task automatic stop_with_failure();
      $display("Test failed");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         $display("Error at time %0t: %s is %h, expected %h", $time, name, got, exp);
         stop_with_failure();
      end
   endtask

   task automatic push_exp(input logic [1:0] ch, input logic [7:0] data,
                           input logic pe, input logic fe);
      uart_link_pkg::read_rec_t rec;
      rec.chan               = ch;
      rec.rx_byte.data       = data;
      rec.rx_byte.parity_err = pe;
      rec.rx_byte.frame_err  = fe;
      rec.overrun            = 1'b0;
      exp_mem[ch][wr_ptr[ch]] = rec;
      wr_ptr[ch] = wr_ptr[ch] + 4'd1;
   endtask

   function automatic logic all_empty();
      logic empty;
      empty = 1'b1;
      for (int i = 0; i < NUM_CHAN; i++) begin
         if (rd_ptr[i] != wr_ptr[i])
            empty = 1'b0;
      end
      return empty;
   endfunction

   task automatic hold_bit();
      repeat (CLKS_PER_BIT) begin
         @(posedge clk);
         #1;
      end
   endtask

   // holds cmd_vld until a cycle where cmd_rdy was high at the edge
   task automatic send_cmd(input logic [1:0] ch, input logic [15:0] w);
      int   waited;
      logic accepted;
      cmd.chan = ch;
      cmd.word = w;
      cmd_vld  = 1'b1;
      accepted = 1'b0;
      waited   = 0;
      while (!accepted) begin
         @(negedge clk);
         accepted = cmd_rdy;
         @(posedge clk);
         #1;
         waited++;
         if (!accepted && waited > SEND_TIMEOUT) begin
            $display("cmd_rdy never rose for a command to channel %0d", ch);
            stop_with_failure();
         end
      end
      cmd_vld = 1'b0;
      push_exp(ch, w[15:8], 1'b0, 1'b0);  // high byte goes out first
      push_exp(ch, w[7:0], 1'b0, 1'b0);
   endtask

   task automatic refuse_cmd(input logic [1:0] ch);
      cmd.chan = ch;
      cmd.word = 16'hdead;
      cmd_vld  = 1'b1;
      @(negedge clk);
      check_value("cmd_rdy", 32'(cmd_rdy), 32'd0);
      @(posedge clk);
      #1;
      cmd_vld = 1'b0;
   endtask

   task automatic inject_frame(input logic [1:0] ch, input logic [7:0] data,
                               input logic bad_par, input logic stop);
      logic                                  par;
      logic [uart_frame_pkg::FRAME_BITS-1:0] frame;
      par   = (~^data) ^ bad_par;
      frame = {stop, par, data, 1'b0};
      gen_line[ch] = 1'b1;
      sel[ch]      = 1'b1;
      for (int b = 0; b < uart_frame_pkg::FRAME_BITS; b++) begin
         gen_line[ch] = frame[b];
         hold_bit();
      end
      gen_line[ch] = 1'b1;
      hold_bit();
      hold_bit();
      sel[ch] = 1'b0;  // tx is idle high, so the switch makes no edge
   endtask

   task automatic drain();
      int waited;
      waited = 0;
      while (!all_empty()) begin
         @(posedge clk);
         #1;
         waited++;
         if (waited > DRAIN_TIMEOUT) begin
            $display("expected records were still missing after %0d cycles", waited);
            stop_with_failure();
         end
      end
   endtask

   // every record must match the oldest outstanding entry of its own channel
   always @(negedge clk) begin
      uart_link_pkg::read_rec_t want;
      if (!rst_n) begin
         for (int i = 0; i < NUM_CHAN; i++)
            rd_ptr[i] = 4'd0;
      end else if (read_vld) begin
         if (rd_ptr[read_rec.chan] == wr_ptr[read_rec.chan]) begin
            $display("A record arrived on channel %0d while none was expected", read_rec.chan);
            stop_with_failure();
         end else begin
            want = exp_mem[read_rec.chan][rd_ptr[read_rec.chan]];
            check_value("read_rec", 32'(read_rec), 32'(want));
            rd_ptr[read_rec.chan] = rd_ptr[read_rec.chan] + 4'd1;
         end
      end
   end

   initial begin
      row_t        row;
      logic [15:0] w;
      int          waited;

      cmd      = '0;
      cmd_vld  = 1'b0;
      sel      = '0;
      gen_line = '1;
      seed     = 32'h279d_ddb2;
      for (int i = 0; i < NUM_CHAN; i++)
         wr_ptr[i] = 4'd0;

      // loopback on each channel alone
      stim_rows[0]  = {ACT_SEND,   2'd0, 1'b1, 16'h0000, 1'b0, 1'b1, 1'b0, 1'b0};
      stim_rows[1]  = {ACT_DRAIN,  2'd0, 1'b0, 16'h0000, 1'b0, 1'b1, 1'b0, 1'b0};
      stim_rows[2]  = {ACT_SEND,   2'd1, 1'b1, 16'h0000, 1'b0, 1'b1, 1'b0, 1'b0};
      stim_rows[3]  = {ACT_DRAIN,  2'd0, 1'b0, 16'h0000, 1'b0, 1'b1, 1'b0, 1'b0};
      stim_rows[4]  = {ACT_SEND,   2'd2, 1'b1, 16'h0000, 1'b0, 1'b1, 1'b0, 1'b0};
      stim_rows[5]  = {ACT_DRAIN,  2'd0, 1'b0, 16'h0000, 1'b0, 1'b1, 1'b0, 1'b0};
      stim_rows[6]  = {ACT_SEND,   2'd3, 1'b1, 16'h0000, 1'b0, 1'b1, 1'b0, 1'b0};
      stim_rows[7]  = {ACT_DRAIN,  2'd0, 1'b0, 16'h0000, 1'b0, 1'b1, 1'b0, 1'b0};
      // holding slot, the third strobe finds both slot and transmitter taken
      stim_rows[8]  = {ACT_SEND,   2'd1, 1'b0, 16'ha55a, 1'b0, 1'b1, 1'b0, 1'b0};
      stim_rows[9]  = {ACT_SEND,   2'd1, 1'b1, 16'h0000, 1'b0, 1'b1, 1'b0, 1'b0};
      stim_rows[10] = {ACT_REFUSE, 2'd1, 1'b0, 16'h0000, 1'b0, 1'b1, 1'b0, 1'b0};
      stim_rows[11] = {ACT_DRAIN,  2'd0, 1'b0, 16'h0000, 1'b0, 1'b1, 1'b0, 1'b0};
      // all channels busy together
      stim_rows[12] = {ACT_SEND,   2'd0, 1'b1, 16'h0000, 1'b0, 1'b1, 1'b0, 1'b0};
      stim_rows[13] = {ACT_SEND,   2'd1, 1'b1, 16'h0000, 1'b0, 1'b1, 1'b0, 1'b0};
      stim_rows[14] = {ACT_SEND,   2'd2, 1'b1, 16'h0000, 1'b0, 1'b1, 1'b0, 1'b0};
      stim_rows[15] = {ACT_SEND,   2'd3, 1'b1, 16'h0000, 1'b0, 1'b1, 1'b0, 1'b0};
      stim_rows[16] = {ACT_DRAIN,  2'd0, 1'b0, 16'h0000, 1'b0, 1'b1, 1'b0, 1'b0};
      // error injection
      stim_rows[17] = {ACT_INJECT, 2'd2, 1'b0, 16'h003c, 1'b1, 1'b1, 1'b1, 1'b0};
      stim_rows[18] = {ACT_DRAIN,  2'd0, 1'b0, 16'h0000, 1'b0, 1'b1, 1'b0, 1'b0};
      stim_rows[19] = {ACT_INJECT, 2'd3, 1'b0, 16'h00c5, 1'b0, 1'b0, 1'b0, 1'b1};
      stim_rows[20] = {ACT_INJECT, 2'd3, 1'b0, 16'h005a, 1'b0, 1'b1, 1'b0, 1'b0};
      stim_rows[21] = {ACT_DRAIN,  2'd0, 1'b0, 16'h0000, 1'b0, 1'b1, 1'b0, 1'b0};

      waited = 0;
      while (rst_n !== 1'b1) begin
         @(posedge clk);
         waited++;
         if (waited > 100) begin
            $display("reset was never released");
            stop_with_failure();
         end
      end

      repeat (6) begin
         @(negedge clk);
         check_value("tx", 32'(tx), 32'hf);
         check_value("read_vld", 32'(read_vld), 32'd0);
         check_value("cmd_rdy", 32'(cmd_rdy), 32'd1);
      end

      @(posedge clk);
      #1;
      for (int r = 0; r < NUM_ROWS; r++) begin
         row = stim_rows[r];
         case (row.act)
            ACT_SEND: begin
               w = row.rnd ? 16'($random(seed)) : row.data;
               send_cmd(row.chan, w);
            end
            ACT_REFUSE: refuse_cmd(row.chan);
            ACT_INJECT: begin
               push_exp(row.chan, row.data[7:0], row.exp_pe, row.exp_fe);
               inject_frame(row.chan, row.data[7:0], row.bad_par, row.stop);
            end
            ACT_DRAIN: drain();
         endcase
      end

      // quiet tail so a stray record would still be caught
      repeat (4 * CLKS_PER_BIT) @(posedge clk);
      if (all_empty() && tx == 4'hf) begin
         $display("Test passed");
         $finish;
      end else begin
         $display("the link did not settle idle with every expected record seen");
         stop_with_failure();
      end
   end

endmodule

`default_nettype wire

//--- uart_rx.sv
`default_nettype none

module uart_rx #(
   parameter int CLKS_PER_BIT = 8
) (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     rx,
   output logic                     byte_vld,
   output uart_frame_pkg::rx_byte_t rx_byte
);

   localparam int CNT_W    = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
   localparam int IDX_W    = $clog2(uart_frame_pkg::FRAME_BITS);
   localparam int HALF_BIT = (CLKS_PER_BIT > 1) ? CLKS_PER_BIT / 2 : 1;

   uart_frame_pkg::rx_state_e state;

   logic                                 rx_s1;
   logic                                 rx_s2;
   logic                                 rx_d;  // previous synchronized level for edge detect
   logic [CNT_W-1:0]                     clk_cnt;
   logic [IDX_W-1:0]                     bit_idx;
   logic [uart_frame_pkg::DATA_BITS-1:0] shift_q;
   logic                                 par_q;
   logic                                 start_edge;
   logic                                 half_end;
   logic                                 bit_end;

   // an edge needs a high level first, so a low line after a bad stop bit is ignored
   assign start_edge = rx_d && !rx_s2;
   assign half_end   = clk_cnt == CNT_W'(HALF_BIT - 1);
   assign bit_end    = clk_cnt == CNT_W'(CLKS_PER_BIT - 1);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rx_s1 <= 1'b1;
         rx_s2 <= 1'b1;
         rx_d  <= 1'b1;
      end else begin
         rx_s1 <= rx;
         rx_s2 <= rx_s1;
         rx_d  <= rx_s2;
      end
   end

   always_ff @(posedge clk) begin
      if (bit_end && state == uart_frame_pkg::RX_DATA)
         shift_q <= {rx_s2, shift_q[uart_frame_pkg::DATA_BITS-1:1]};  // lsb arrives first
      if (bit_end && state == uart_frame_pkg::RX_PARITY)
         par_q <= rx_s2;
      if (bit_end && state == uart_frame_pkg::RX_STOP) begin
         rx_byte.data       <= shift_q;
         rx_byte.parity_err <= ~^{shift_q, par_q};
         rx_byte.frame_err  <= !rx_s2;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state    <= uart_frame_pkg::RX_IDLE;
         clk_cnt  <= '0;
         bit_idx  <= '0;
         byte_vld <= 1'b0;
      end else begin
         byte_vld <= 1'b0;
         case (state)
            uart_frame_pkg::RX_IDLE: begin
               clk_cnt <= '0;
               if (start_edge)
                  state <= uart_frame_pkg::RX_START;
            end
            uart_frame_pkg::RX_START: begin
               if (!half_end) begin
                  clk_cnt <= clk_cnt + 1'b1;
               end else begin
                  // from here on every sample lands in the middle of a bit
                  clk_cnt <= '0;
                  bit_idx <= '0;
                  state   <= rx_s2 ? uart_frame_pkg::RX_IDLE : uart_frame_pkg::RX_DATA;
               end
            end
            default: begin
               if (!bit_end) begin
                  clk_cnt <= clk_cnt + 1'b1;
               end else begin
                  clk_cnt <= '0;
                  if (state == uart_frame_pkg::RX_DATA) begin
                     bit_idx <= bit_idx + 1'b1;
                     if (bit_idx == IDX_W'(uart_frame_pkg::DATA_BITS - 1))
                        state <= uart_frame_pkg::RX_PARITY;
                  end else if (state == uart_frame_pkg::RX_PARITY) begin
                     state <= uart_frame_pkg::RX_STOP;
                  end else begin
                     byte_vld <= 1'b1;
                     state    <= uart_frame_pkg::RX_IDLE;
                  end
               end
            end
         endcase
      end
   end

endmodule

`default_nettype wire

//--- uart_tx.sv
`default_nettype none

module uart_tx #(
   parameter int CLKS_PER_BIT = 8
) (
   input  logic        clk,
   input  logic        rst_n,
   input  logic        load,
   input  logic [15:0] word,
   output logic        tx,
   output logic        busy
);

   localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
   localparam int IDX_W = $clog2(uart_frame_pkg::FRAME_BITS);

   uart_frame_pkg::tx_state_e state;

   logic [CNT_W-1:0]                     clk_cnt;
   logic [IDX_W-1:0]                     bit_idx;
   logic                                 byte_sel;  // 0 while the high byte is on the line
   logic [15:0]                          word_q;
   logic [1:0]                           par_q;     // odd parity of high and low byte
   logic [uart_frame_pkg::DATA_BITS-1:0] shift_q;
   logic [uart_frame_pkg::DATA_BITS-1:0] cur_byte;
   logic                                 cur_par;
   logic                                 bit_end;

   assign bit_end  = clk_cnt == CNT_W'(CLKS_PER_BIT - 1);
   assign cur_byte = byte_sel ? word_q[7:0] : word_q[15:8];
   assign cur_par  = byte_sel ? par_q[0] : par_q[1];
   assign busy     = state != uart_frame_pkg::TX_IDLE;

   // both parity bits are ready before the first start bit goes out
   always_ff @(posedge clk) begin
      if (load && !busy) begin
         word_q <= word;
         par_q  <= {~^word[15:8], ~^word[7:0]};
      end
      if (bit_end && state == uart_frame_pkg::TX_START)
         shift_q <= cur_byte >> 1;  // bit 0 leaves straight from cur_byte
      else if (bit_end && state == uart_frame_pkg::TX_DATA)
         shift_q <= shift_q >> 1;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state    <= uart_frame_pkg::TX_IDLE;
         clk_cnt  <= '0;
         bit_idx  <= '0;
         byte_sel <= 1'b0;
         tx       <= 1'b1;
      end else if (state == uart_frame_pkg::TX_IDLE) begin
         clk_cnt <= '0;
         if (load) begin
            state    <= uart_frame_pkg::TX_START;
            byte_sel <= 1'b0;
            tx       <= 1'b0;
         end
      end else if (!bit_end) begin
         clk_cnt <= clk_cnt + 1'b1;
      end else begin
         clk_cnt <= '0;
         case (state)
            uart_frame_pkg::TX_START: begin
               state   <= uart_frame_pkg::TX_DATA;
               bit_idx <= '0;
               tx      <= cur_byte[0];
            end
            uart_frame_pkg::TX_DATA: begin
               if (bit_idx == IDX_W'(uart_frame_pkg::DATA_BITS - 1)) begin
                  state <= uart_frame_pkg::TX_PARITY;
                  tx    <= cur_par;
               end else begin
                  bit_idx <= bit_idx + 1'b1;
                  tx      <= shift_q[0];
               end
            end
            uart_frame_pkg::TX_PARITY: begin
               state <= uart_frame_pkg::TX_STOP;
               tx    <= 1'b1;
            end
            uart_frame_pkg::TX_STOP: begin
               if (!byte_sel) begin
                  // the low byte frame follows with no idle gap
                  byte_sel <= 1'b1;
                  state    <= uart_frame_pkg::TX_START;
                  tx       <= 1'b0;
               end else begin
                  state <= uart_frame_pkg::TX_IDLE;
               end
            end
            default: state <= uart_frame_pkg::TX_IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire
